// ==== rv_pipe.f ====
+incdir+hw
+incdir+test
hw/rv_pipe_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_retire.sv
hw/rv_pipe_top.sv
test/rv_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the rv_pipe testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f rv_pipe.f --top-module rv_pipe_tb -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vrv_pipe_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

// ==== test/rv_pipe_tb_table.svh ====
/* stimulus table of instruction words, fetch addresses and
   expected write-backs, worked out by hand from RV32I semantics */
`ifndef RV_PIPE_TB_TABLE_SVH
`define RV_PIPE_TB_TABLE_SVH

localparam int TBL_LEN = 25;

// columns: instruction word, fetch address, '{we, waddr, wdata}
localparam tbl_entry_t STIM_TABLE [TBL_LEN] = '{
    '{32'h00500093, 32'h00000100, '{1'b1, 5'd1,  32'h00000005}},  // addi x1, x0, 5
    '{32'hffd08113, 32'h00000104, '{1'b1, 5'd2,  32'h00000002}},  // addi x2, x1, -3
    '{32'h402081b3, 32'h00000108, '{1'b1, 5'd3,  32'h00000003}},  // sub x3, x1, x2
    '{32'h00308233, 32'h0000010c, '{1'b1, 5'd4,  32'h00000008}},  // add x4, x1, x3
    '{32'hfffff2b7, 32'h00000110, '{1'b1, 5'd5,  32'hfffff000}},  // lui x5, 0xfffff
    '{32'h4042d313, 32'h00000114, '{1'b1, 5'd6,  32'hffffff00}},  // srai x6, x5, 4
    '{32'h0042d393, 32'h00000118, '{1'b1, 5'd7,  32'h0fffff00}},  // srli x7, x5, 4
    '{32'h4012d433, 32'h0000011c, '{1'b1, 5'd8,  32'hffffff80}},  // sra x8, x5, x1
    '{32'h0050b4b3, 32'h00000120, '{1'b1, 5'd9,  32'h00000001}},  // sltu x9, x1, x5
    '{32'h0012a533, 32'h00000124, '{1'b1, 5'd10, 32'h00000001}},  // slt x10, x5, x1
    '{32'hfff2a593, 32'h00000128, '{1'b1, 5'd11, 32'h00000001}},  // slti x11, x5, -1
    '{32'hfff0b613, 32'h0000012c, '{1'b1, 5'd12, 32'h00000001}},  // sltiu x12, x1, -1
    '{32'h0f024693, 32'h00000130, '{1'b1, 5'd13, 32'h000000f8}},  // xori x13, x4, 0xf0
    '{32'h7006e713, 32'h00000134, '{1'b1, 5'd14, 32'h000007f8}},  // ori x14, x13, 0x700
    '{32'h0ff77793, 32'h00000138, '{1'b1, 5'd15, 32'h000000f8}},  // andi x15, x14, 0xff
    '{32'h00309813, 32'h0000013c, '{1'b1, 5'd16, 32'h00000028}},  // slli x16, x1, 3
    '{32'h12345897, 32'h00000140, '{1'b1, 5'd17, 32'h12345140}},  // auipc x17, 0x12345
    '{32'h00708013, 32'h00000144, '{1'b1, 5'd0,  32'h0000000c}},  // addi x0, x1, 7
    '{32'h00100933, 32'h00000148, '{1'b1, 5'd18, 32'h00000005}},  // add x18, x0, x1
    '{32'h00002083, 32'h0000014c, '{1'b0, 5'd0,  32'h00000000}},  // unsupported lw
    '{32'h00c6e9b3, 32'h00000150, '{1'b1, 5'd19, 32'h000000f9}},  // or x19, x13, x12
    '{32'h00f9fa33, 32'h00000154, '{1'b1, 5'd20, 32'h000000f8}},  // and x20, x19, x15
    '{32'h005a4ab3, 32'h00000158, '{1'b1, 5'd21, 32'hfffff0f8}},  // xor x21, x20, x5
    '{32'h01009b33, 32'h0000015c, '{1'b1, 5'd22, 32'h00000500}},  // sll x22, x1, x16
    '{32'h0012dbb3, 32'h00000160, '{1'b1, 5'd23, 32'h07ffff80}}   // srl x23, x5, x1
};

`endif

// ==== test/rv_pipe_tb.sv ====
/* testbench for the RV32I pipeline: clock, reset, LFSR gaps,
   table-driven stimulus, write-back compare tasks and watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_GAP    = 3;

    typedef struct packed {
        logic [`RV_XLEN-1:0] inst;
        logic [`RV_XLEN-1:0] addr;
        reg_wr_t             exp;
    } tbl_entry_t;

    `include "rv_pipe_tb_table.svh"

    // two passes, each with reset, drain and pipeline depth, doubled for margin
    localparam int WATCHDOG_CYCLES = 2 * 2 * (TBL_LEN * (MAX_GAP + 1) + 9 + 6 + 4);
    localparam reg_wr_t NO_WR      = '0;

    logic                clk;
    logic                arst_n;
    logic                inst_valid;
    logic [`RV_XLEN-1:0] inst_addr;
    rv_inst_u            inst;
    reg_wr_t             wb;

    reg_wr_t             exp_q [$];  // one entry per driven cycle
    logic [31:0]         lfsr;
    int                  wr_errs;
    int                  idle_errs;

    rv_pipe_top u_dut (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .inst_valid_i (inst_valid),
        .inst_addr_i  (inst_addr),
        .inst_i       (inst),
        .wb_o         (wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        bits = '0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[0], lfsr[0]};
        end
        gap = int'(bits);
    endtask

    task automatic check_wr(input reg_wr_t exp, input reg_wr_t act);
        if (act !== exp) begin
            wr_errs++;
            $display("error wb_o: expected we=%h waddr=%h wdata=%h, actual we=%h waddr=%h wdata=%h",
                     exp.we, exp.waddr, exp.wdata, act.we, act.waddr, act.wdata);
        end
    endtask

    task automatic check_idle(input reg_wr_t act);
        if (act.we !== 1'b0) begin
            idle_errs++;
            $display("error wb_o.we: expected %h, actual %h (waddr=%h wdata=%h)",
                     1'b0, act.we, act.waddr, act.wdata);
        end
    endtask

    task automatic apply_reset();
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        exp_q.delete();
        repeat (8) @(posedge clk);
        #2;
        arst_n = 1'b1;
        exp_q.push_back(NO_WR);  // release cycle counts as idle
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        exp_q.push_back(NO_WR);
    endtask

    task automatic issue(input tbl_entry_t e);
        @(posedge clk);
        #2;
        inst_valid = 1'b1;
        inst_addr  = e.addr;
        inst       = e.inst;
        exp_q.push_back(e.exp);
    endtask

    // driven after edge k, seen on wb_o after edge k+4
    always @(negedge clk) begin
        reg_wr_t exp;
        if (arst_n) begin
            if (exp_q.size() > 4) begin
                exp = exp_q.pop_front();
                if (exp.we) begin
                    check_wr(exp, wb);
                end else begin
                    check_idle(wb);
                end
            end else begin
                check_idle(wb);
            end
        end
    end

    initial begin
        int gap;
        inst_valid = 1'b0;
        inst_addr  = '0;
        inst       = '0;
        arst_n     = 1'b0;
        lfsr       = 32'h242d;
        wr_errs    = 0;
        idle_errs  = 0;
        apply_reset();
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < TBL_LEN; i++) begin
                issue(STIM_TABLE[i]);
                gap = 0;
                if (pass == 1) begin
                    draw_gap(gap);  // mixed hazard distances
                end
                repeat (gap) idle_cycle();
            end
            repeat (6) idle_cycle();
            if (pass == 0) begin
                apply_reset();
            end
        end
        $display("wb_o mismatches: %0d, unexpected writes: %0d", wr_errs, idle_errs);
        if (wr_errs == 0 && idle_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the test sequence did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/rv_pipe_top.sv ====
/* RV32I integer pipeline top
   decode, register file, execute and retire */
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module rv_pipe_top (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    inst_valid_i,
    input  logic [`RV_XLEN-1:0]     inst_addr_i,
    input  rv_pipe_pkg::rv_inst_u   inst_i,
    output rv_pipe_pkg::reg_wr_t    wb_o
);
    import rv_pipe_pkg::*;

    logic [`RV_REG_ADDR_W-1:0]   rd1_addr;
    logic                        rd1_en;
    logic [`RV_REG_ADDR_W-1:0]   rd2_addr;
    logic                        rd2_en;
    logic [`RV_XLEN-1:0]         rd1_data;
    logic [`RV_XLEN-1:0]         rd2_data;
    id_exe_t                     id_exe;
    reg_wr_t                     exe_fwd;
    reg_wr_t                     mem_fwd;

    rv_decode u_decode (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_addr_i  (inst_addr_i),
        .inst_i       (inst_i),
        .rd1_data_i   (rd1_data),
        .rd2_data_i   (rd2_data),
        .exe_fwd_i    (exe_fwd),
        .mem_fwd_i    (mem_fwd),
        .rd1_addr_o   (rd1_addr),
        .rd1_en_o     (rd1_en),
        .rd2_addr_o   (rd2_addr),
        .rd2_en_o     (rd2_en),
        .id_exe_o     (id_exe)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd1_addr_i (rd1_addr),
        .rd1_en_i   (rd1_en),
        .rd2_addr_i (rd2_addr),
        .rd2_en_i   (rd2_en),
        .wr_i       (wb_o),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data)
    );

    rv_execute u_execute (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .id_exe_i  (id_exe),
        .exe_fwd_o (exe_fwd)
    );

    rv_retire u_retire (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .exe_fwd_i (exe_fwd),
        .mem_fwd_o (mem_fwd),
        .wb_o      (wb_o)
    );

endmodule

`default_nettype wire

// ==== hw/rv_retire.sv ====
/* memory-stage and write-back registers,
   forward from memory and the register file write */
`timescale 1ns/1ps
`default_nettype none

module rv_retire (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  rv_pipe_pkg::reg_wr_t    exe_fwd_i,
    output rv_pipe_pkg::reg_wr_t    mem_fwd_o,
    output rv_pipe_pkg::reg_wr_t    wb_o
);

    // memory stage only carries the result
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_fwd_o <= '0;
            wb_o      <= '0;
        end else begin
            mem_fwd_o <= exe_fwd_i;
            wb_o      <= mem_fwd_o;  // regfile writes on the next edge
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
/* decode-to-execute register and ALU,
   result also serves as the forward from execute */
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module rv_execute (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  rv_pipe_pkg::id_exe_t    id_exe_i,
    output rv_pipe_pkg::reg_wr_t    exe_fwd_o
);
    import rv_pipe_pkg::*;

    alu_op_e                     alu_op_q;
    logic                        reg_we_q;
    logic [`RV_REG_ADDR_W-1:0]   reg_waddr_q;
    logic [`RV_XLEN-1:0]         op1_q;
    logic [`RV_XLEN-1:0]         op2_q;

    logic [4:0]                  shamt;
    logic [`RV_XLEN-1:0]         result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_op_q <= ALU_NOP;
            reg_we_q <= 1'b0;
        end else begin
            alu_op_q <= id_exe_i.alu_op;
            reg_we_q <= id_exe_i.reg_we;
        end
    end

    always_ff @(posedge clk_i) begin
        reg_waddr_q <= id_exe_i.reg_waddr;
        op1_q       <= id_exe_i.op1;
        op2_q       <= id_exe_i.op2;
    end

    assign shamt = op2_q[4:0];

    always_comb begin
        result = '0;
        case (alu_op_q)
            ALU_ADD:    result = op1_q + op2_q;
            ALU_SUB:    result = op1_q - op2_q;
            ALU_SLL:    result = op1_q << shamt;
            ALU_SLT:    result[0] = $signed(op1_q) < $signed(op2_q);
            ALU_SLTU:   result[0] = op1_q < op2_q;
            ALU_XOR:    result = op1_q ^ op2_q;
            ALU_SRL:    result = op1_q >> shamt;
            ALU_SRA:    result = $signed(op1_q) >>> shamt;
            ALU_OR:     result = op1_q | op2_q;
            ALU_AND:    result = op1_q & op2_q;
            ALU_PASS_B: result = op2_q;
            default:    result = '0;  // bubble
        endcase
    end

    always_comb begin
        exe_fwd_o.we    = reg_we_q;
        exe_fwd_o.waddr = reg_waddr_q;
        exe_fwd_o.wdata = result;
    end

endmodule

`default_nettype wire

// ==== hw/rv_decode.sv ====
/* instruction input latch, field decode and immediate build,
   register read requests and operand forwarding from execute and memory */
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module rv_decode (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        inst_valid_i,
    input  logic [`RV_XLEN-1:0]         inst_addr_i,
    input  rv_pipe_pkg::rv_inst_u       inst_i,
    input  logic [`RV_XLEN-1:0]         rd1_data_i,
    input  logic [`RV_XLEN-1:0]         rd2_data_i,
    input  rv_pipe_pkg::reg_wr_t        exe_fwd_i,
    input  rv_pipe_pkg::reg_wr_t        mem_fwd_i,
    output logic [`RV_REG_ADDR_W-1:0]   rd1_addr_o,
    output logic                        rd1_en_o,
    output logic [`RV_REG_ADDR_W-1:0]   rd2_addr_o,
    output logic                        rd2_en_o,
    output rv_pipe_pkg::id_exe_t        id_exe_o
);
    import rv_pipe_pkg::*;

    logic                  valid_q;
    rv_inst_u              inst_q;
    logic [`RV_XLEN-1:0]   addr_q;

    alu_op_e               alu_op;
    logic [`RV_XLEN-1:0]   imm;
    logic                  op1_is_pc;  // auipc
    logic                  reg_we;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= inst_valid_i;  // no strobe -> bubble
        end
    end

    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            inst_q <= inst_i;
            addr_q <= inst_addr_i;
        end
    end

    // funct3 mapping shared by op-imm and op with funct7 zero
    function automatic alu_op_e base_op(input logic [2:0] funct3);
        case (funct3)
            `RV_F3_ADD_SUB: return ALU_ADD;
            `RV_F3_SLL:     return ALU_SLL;
            `RV_F3_SLT:     return ALU_SLT;
            `RV_F3_SLTU:    return ALU_SLTU;
            `RV_F3_XOR:     return ALU_XOR;
            `RV_F3_SRL_SRA: return ALU_SRL;
            `RV_F3_OR:      return ALU_OR;
            default:        return ALU_AND;
        endcase
    endfunction

    function automatic logic [`RV_XLEN-1:0] fwd_operand(
        input logic                      en,
        input logic [`RV_REG_ADDR_W-1:0] addr,
        input logic [`RV_XLEN-1:0]       rdata,
        input logic [`RV_XLEN-1:0]       imm_val,
        input reg_wr_t                   exe,
        input reg_wr_t                   mem
    );
        if (!en) begin
            return imm_val;
        end
        if (addr == '0) begin
            return rdata;  // x0 is never forwarded
        end
        if (exe.we && exe.waddr == addr) begin
            return exe.wdata;
        end
        if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end
        return rdata;
    endfunction

    always_comb begin
        alu_op    = ALU_NOP;
        rd1_en_o  = 1'b0;
        rd2_en_o  = 1'b0;
        op1_is_pc = 1'b0;
        imm       = {{(`RV_XLEN-12){inst_q.i.imm12[11]}}, inst_q.i.imm12};
        if (valid_q) begin
            case (inst_q.r.opcode)
                `RV_OP_IMM: begin
                    rd1_en_o = 1'b1;
                    alu_op   = base_op(inst_q.i.funct3);
                    if (inst_q.i.funct3 == `RV_F3_SLL && inst_q.r.funct7 != `RV_F7_BASE) begin
                        alu_op = ALU_NOP;
                    end else if (inst_q.i.funct3 == `RV_F3_SRL_SRA) begin
                        if (inst_q.r.funct7 == `RV_F7_ALT) begin
                            alu_op = ALU_SRA;
                        end else if (inst_q.r.funct7 != `RV_F7_BASE) begin
                            alu_op = ALU_NOP;
                        end
                    end
                end
                `RV_OP_REG: begin
                    rd1_en_o = 1'b1;
                    rd2_en_o = 1'b1;
                    if (inst_q.r.funct7 == `RV_F7_BASE) begin
                        alu_op = base_op(inst_q.r.funct3);
                    end else if (inst_q.r.funct7 == `RV_F7_ALT) begin
                        case (inst_q.r.funct3)
                            `RV_F3_ADD_SUB: alu_op = ALU_SUB;
                            `RV_F3_SRL_SRA: alu_op = ALU_SRA;
                            default:        alu_op = ALU_NOP;
                        endcase
                    end
                end
                `RV_OP_LUI: begin
                    alu_op = ALU_PASS_B;
                    imm    = {inst_q.u.imm20, 12'b0};
                end
                `RV_OP_AUIPC: begin
                    alu_op    = ALU_ADD;
                    imm       = {inst_q.u.imm20, 12'b0};
                    op1_is_pc = 1'b1;
                end
                default: alu_op = ALU_NOP;
            endcase
            if (alu_op == ALU_NOP) begin  // unsupported, retire as bubble
                rd1_en_o = 1'b0;
                rd2_en_o = 1'b0;
            end
        end
    end

    assign reg_we     = (alu_op != ALU_NOP);
    assign rd1_addr_o = rd1_en_o ? inst_q.r.rs1 : '0;
    assign rd2_addr_o = rd2_en_o ? inst_q.r.rs2 : '0;

    always_comb begin
        id_exe_o.alu_op    = alu_op;
        id_exe_o.reg_we    = reg_we;
        id_exe_o.reg_waddr = reg_we ? inst_q.r.rd : '0;
        if (op1_is_pc) begin
            id_exe_o.op1 = addr_q;
        end else begin
            id_exe_o.op1 = fwd_operand(rd1_en_o, rd1_addr_o, rd1_data_i, imm,
                                       exe_fwd_i, mem_fwd_i);
        end
        id_exe_o.op2 = fwd_operand(rd2_en_o, rd2_addr_o, rd2_data_i, imm,
                                   exe_fwd_i, mem_fwd_i);
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
/* 32-entry register file, two read ports and one write port,
   x0 held at zero, write-through on a same-cycle read */
`timescale 1ns/1ps
`default_nettype none
`include "rv_pipe_settings.svh"

module rv_regfile (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rd1_addr_i,
    input  logic                        rd1_en_i,
    input  logic [`RV_REG_ADDR_W-1:0]   rd2_addr_i,
    input  logic                        rd2_en_i,
    input  rv_pipe_pkg::reg_wr_t        wr_i,
    output logic [`RV_XLEN-1:0]         rd1_data_o,
    output logic [`RV_XLEN-1:0]         rd2_data_o
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_NUM];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.we && wr_i.waddr != '0) begin  // x0 writes dropped
            regs[wr_i.waddr] <= wr_i.wdata;
        end
    end

    function automatic logic [`RV_XLEN-1:0] read_port(
        input logic                      en,
        input logic [`RV_REG_ADDR_W-1:0] addr
    );
        if (!en || addr == '0) begin
            return '0;
        end
        // distance-three hazard lands here
        if (wr_i.we && wr_i.waddr == addr) begin
            return wr_i.wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1_data_o = read_port(rd1_en_i, rd1_addr_i);
        rd2_data_o = read_port(rd2_en_i, rd2_addr_i);
    end

endmodule

`default_nettype wire

// ==== hw/rv_pipe_pkg.sv ====
/* instruction word union, ALU operation enum,
   write-back and decode-to-execute stage structs */
`default_nettype none
`include "rv_pipe_settings.svh"

package rv_pipe_pkg;

    typedef struct packed {
        logic [6:0]                  funct7;
        logic [`RV_REG_ADDR_W-1:0]   rs2;
        logic [`RV_REG_ADDR_W-1:0]   rs1;
        logic [2:0]                  funct3;
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [6:0]                  opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0]                 imm12;
        logic [`RV_REG_ADDR_W-1:0]   rs1;
        logic [2:0]                  funct3;
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [6:0]                  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [19:0]                 imm20;
        logic [`RV_REG_ADDR_W-1:0]   rd;
        logic [6:0]                  opcode;
    } inst_u_t;

    // one instruction word, three views
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_u_t u;
    } rv_inst_u;

    typedef enum logic [3:0] {
        ALU_NOP    = 4'd0,
        ALU_ADD    = 4'd1,
        ALU_SUB    = 4'd2,
        ALU_SLL    = 4'd3,
        ALU_SLT    = 4'd4,
        ALU_SLTU   = 4'd5,
        ALU_XOR    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_OR     = 4'd9,
        ALU_AND    = 4'd10,
        ALU_PASS_B = 4'd11   // lui
    } alu_op_e;

    typedef struct packed {
        logic                        we;
        logic [`RV_REG_ADDR_W-1:0]   waddr;
        logic [`RV_XLEN-1:0]         wdata;
    } reg_wr_t;

    typedef struct packed {
        alu_op_e                     alu_op;
        logic [`RV_XLEN-1:0]         op1;
        logic [`RV_XLEN-1:0]         op2;
        logic                        reg_we;
        logic [`RV_REG_ADDR_W-1:0]   reg_waddr;
    } id_exe_t;

endpackage

`default_nettype wire

// ==== hw/rv_pipe_settings.svh ====
/* data and register widths, register count
   RV32I opcode, funct3 and funct7 encodings for the integer subset */
`ifndef RV_PIPE_SETTINGS_SVH
`define RV_PIPE_SETTINGS_SVH

`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_REG_NUM      32

// major opcodes
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111

`define RV_F3_ADD_SUB   3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL_SRA   3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000  // sub, sra, srai

`endif
